//--- source/taylor_pkg.sv
// Q2.16 fixed-point type, function select and DSP select enums, DSP command and result structs

package taylor_pkg;

    // ----------------------------------------------------------
    // Fixed-point format
    // ----------------------------------------------------------

    // Q2.16, so 1.0 is 0x10000
    localparam int FRAC_BITS = 16;
    localparam int FIXED_W   = 18;

    typedef logic signed [FIXED_W-1:0] fixed_t;

    localparam fixed_t FIXED_ONE = fixed_t'(1 << FRAC_BITS);

    // DSP slice widths
    localparam int MULT_W = 2 * FIXED_W;
    localparam int ACC_W  = 48;

    // ----------------------------------------------------------
    // Function select
    // ----------------------------------------------------------

    typedef enum logic [2:0] {
        FUNC_COS  = 3'd0,
        FUNC_SIN  = 3'd1,
        FUNC_EXP  = 3'd2,
        FUNC_COSH = 3'd3,
        FUNC_SINH = 3'd4
    } taylor_func_e;

    // ----------------------------------------------------------
    // MAC slice command and result
    // ----------------------------------------------------------

    // Accumulator product input
    typedef enum logic {
        XSEL_ZERO = 1'b0,
        XSEL_MULT = 1'b1
    } dsp_xsel_e;

    // Accumulator feedback input
    typedef enum logic {
        ZSEL_ZERO = 1'b0,
        ZSEL_POUT = 1'b1
    } dsp_zsel_e;

    // 39 bits, one command per cycle
    typedef struct packed {
        logic      hold;
        dsp_xsel_e xsel;
        dsp_zsel_e zsel;
        fixed_t    a;
        fixed_t    b;
    } dsp_cmd_t;

    // 84 bits
    typedef struct packed {
        logic signed [MULT_W-1:0] m;
        logic signed [ACC_W-1:0]  p;
    } dsp_res_t;

endpackage

//--- source/taylor_coef_rom.sv
// Derivative-at-zero coefficient table, indexed by function and term
`timescale 1ns/1ps

module taylor_coef_rom (
    input  taylor_pkg::taylor_func_e func_sel,
    input  logic [3:0]               term_idx,
    output taylor_pkg::fixed_t       coef
);

    localparam taylor_pkg::fixed_t COEF_POS = taylor_pkg::FIXED_ONE;
    localparam taylor_pkg::fixed_t COEF_NEG = -taylor_pkg::FIXED_ONE;

    // Bit 0 picks even/odd terms, bit 1 flips the sign for cos/sin
    always_comb begin
        coef = '0;
        case (func_sel)
            taylor_pkg::FUNC_COS: begin
                if (!term_idx[0]) begin
                    coef = term_idx[1] ? COEF_NEG : COEF_POS;
                end
            end
            taylor_pkg::FUNC_SIN: begin
                if (term_idx[0]) begin
                    coef = term_idx[1] ? COEF_NEG : COEF_POS;
                end
            end
            taylor_pkg::FUNC_EXP: begin
                coef = COEF_POS;
            end
            taylor_pkg::FUNC_COSH: begin
                if (!term_idx[0]) begin
                    coef = COEF_POS;
                end
            end
            taylor_pkg::FUNC_SINH: begin
                if (term_idx[0]) begin
                    coef = COEF_POS;
                end
            end
            // Unused select codes
            default: begin
                coef = '0;
            end
        endcase
    end

endmodule

//--- source/dsp_mac_slice.sv
// Two-stage signed multiplier with 48-bit accumulator and X/Z input selects
`timescale 1ns/1ps

module dsp_mac_slice (
    input  logic                 reset,
    input  logic                 clk,
    input  taylor_pkg::dsp_cmd_t cmd,
    output taylor_pkg::dsp_res_t res
);

    localparam int MW = taylor_pkg::MULT_W;
    localparam int AW = taylor_pkg::ACC_W;

    taylor_pkg::dsp_cmd_t cmd_q;
    logic signed [MW-1:0] prod;
    logic signed [MW-1:0] m_q;
    logic signed [AW-1:0] x_mux;
    logic signed [AW-1:0] z_mux;
    logic signed [AW-1:0] p_q;
    logic                 acc_live;

    // ----------------------------------------------------------
    // Stage 1: command register
    // ----------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            cmd_q <= '{hold: 1'b1, xsel: taylor_pkg::XSEL_ZERO,
                       zsel: taylor_pkg::ZSEL_ZERO, a: '0, b: '0};
        end else begin
            cmd_q <= cmd;
        end
    end

    // ----------------------------------------------------------
    // Stage 2: product and accumulator
    // ----------------------------------------------------------
    assign prod  = $signed(cmd_q.a) * $signed(cmd_q.b);
    assign x_mux = (cmd_q.xsel == taylor_pkg::XSEL_MULT) ?
                   {{(AW-MW){prod[MW-1]}}, prod} : '0;
    assign z_mux = (cmd_q.zsel == taylor_pkg::ZSEL_POUT) ? p_q : '0;

    always_ff @(posedge reset) begin
        m_q <= prod;
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            p_q      <= '0;
            acc_live <= 1'b0;
        end else if (!cmd_q.hold) begin
            p_q <= x_mux + z_mux;
            if (cmd_q.zsel == taylor_pkg::ZSEL_ZERO) begin
                acc_live <= 1'b1;
            end
        end
    end

    assign res.m = m_q;
    assign res.p = p_q;

    // Feedback from p only after a fresh accumulation has been started
    a_pout_after_start: assert property (
        @(posedge reset) disable iff (clk)
        (!cmd_q.hold && cmd_q.zsel == taylor_pkg::ZSEL_POUT) |-> acc_live
    ) else $error("accumulator feedback used before a ZSEL_ZERO start");

endmodule

//--- source/taylor_sequencer.sv
// Taylor series sequencer: program counter, index registers, reciprocal table, value arrays
`timescale 1ns/1ps

module taylor_sequencer #(
    parameter int N_TERMS = 10
) (
    input  logic                     reset,
    input  logic                     clk,
    input  logic                     do_calc,
    input  taylor_pkg::taylor_func_e func_sel,
    input  taylor_pkg::fixed_t       x_in,
    output logic                     calc_done,
    output taylor_pkg::fixed_t       result,
    output taylor_pkg::taylor_func_e func_sel_q,
    output logic [3:0]               term_idx,
    input  taylor_pkg::fixed_t       coef,
    output taylor_pkg::dsp_cmd_t     dsp_cmd,
    input  taylor_pkg::dsp_res_t     dsp_res
);

    localparam int         FB   = taylor_pkg::FRAC_BITS;
    localparam int         FW   = taylor_pkg::FIXED_W;
    localparam logic [3:0] LAST = 4'(N_TERMS);

    typedef enum logic [2:0] {
        WAIT,
        INIT,
        G_ISSUE,
        CHAIN,
        ACCUM,
        DRAIN,
        DONE
    } seq_state_e;

    // Destination of a multiply coming back from the slice
    typedef struct packed {
        logic       valid;
        logic       to_val;
        logic [3:0] idx;
    } wb_tag_t;

    seq_state_e         state;
    logic [3:0]         i;
    logic [3:0]         j;
    logic [1:0]         rep;
    taylor_pkg::fixed_t x_q;
    taylor_pkg::fixed_t recip_j;
    taylor_pkg::fixed_t m_frac;
    wb_tag_t            issue_tag;
    wb_tag_t            wb_q [2];

    taylor_pkg::fixed_t g   [1:N_TERMS];
    taylor_pkg::fixed_t val [0:N_TERMS];

    if (N_TERMS < 4 || N_TERMS > 10) begin : g_bad_terms
        $error("N_TERMS must lie within 4 to 10");
    end

    // ----------------------------------------------------------
    // Program counter and index registers
    // ----------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= WAIT;
            i     <= '0;
            j     <= '0;
            rep   <= '0;
        end else begin
            case (state)
                WAIT: begin
                    if (do_calc) begin
                        state <= INIT;
                    end
                end
                INIT: begin
                    i     <= '0;
                    j     <= 4'd1;
                    state <= G_ISSUE;
                end
                // One x/j per cycle
                G_ISSUE: begin
                    if (j == LAST) begin
                        j     <= 4'd1;
                        rep   <= '0;
                        state <= CHAIN;
                    end else begin
                        j <= j + 4'd1;
                    end
                end
                // Issue on rep 0, wait for write-back on 1 and 2
                CHAIN: begin
                    if (rep == 2'd2) begin
                        rep <= '0;
                        if (j == LAST) begin
                            i     <= '0;
                            state <= ACCUM;
                        end else begin
                            j <= j + 4'd1;
                        end
                    end else begin
                        rep <= rep + 2'd1;
                    end
                end
                ACCUM: begin
                    if (i == LAST) begin
                        rep   <= '0;
                        state <= DRAIN;
                    end else begin
                        i <= i + 4'd1;
                    end
                end
                DRAIN: begin
                    if (rep == 2'd1) begin
                        rep   <= '0;
                        state <= DONE;
                    end else begin
                        rep <= rep + 2'd1;
                    end
                end
                DONE: begin
                    state <= WAIT;
                end
                default: begin
                    state <= WAIT;
                end
            endcase
        end
    end

    // Inputs latched only while waiting
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            func_sel_q <= taylor_pkg::FUNC_COS;
        end else if (state == WAIT && do_calc) begin
            func_sel_q <= func_sel;
        end
    end

    always_ff @(posedge reset) begin
        if (state == WAIT && do_calc) begin
            x_q <= x_in;
        end
    end

    assign term_idx = i;

    // ----------------------------------------------------------
    // Reciprocal table, Q16 values of 1/j
    // ----------------------------------------------------------
    always_comb begin
        case (j)
            4'd1:    recip_j = 18'h10000;
            4'd2:    recip_j = 18'h08000;
            4'd3:    recip_j = 18'h05555;
            4'd4:    recip_j = 18'h04000;
            4'd5:    recip_j = 18'h03333;
            4'd6:    recip_j = 18'h02aab;
            4'd7:    recip_j = 18'h02492;
            4'd8:    recip_j = 18'h02000;
            4'd9:    recip_j = 18'h01c72;
            4'd10:   recip_j = 18'h0199a;
            default: recip_j = '0;
        endcase
    end

    // ----------------------------------------------------------
    // MAC command
    // ----------------------------------------------------------
    always_comb begin
        dsp_cmd = '{hold: 1'b1, xsel: taylor_pkg::XSEL_ZERO,
                    zsel: taylor_pkg::ZSEL_POUT, a: '0, b: '0};
        issue_tag = '0;
        case (state)
            G_ISSUE: begin
                dsp_cmd.a = x_q;
                dsp_cmd.b = recip_j;
                issue_tag = '{valid: 1'b1, to_val: 1'b0, idx: j};
            end
            CHAIN: begin
                if (rep == 2'd0) begin
                    dsp_cmd.a = val[j - 4'd1];
                    dsp_cmd.b = g[j];
                    issue_tag = '{valid: 1'b1, to_val: 1'b1, idx: j};
                end
            end
            ACCUM: begin
                dsp_cmd.hold = 1'b0;
                dsp_cmd.xsel = taylor_pkg::XSEL_MULT;
                // First term starts a fresh sum
                if (i == 4'd0) begin
                    dsp_cmd.zsel = taylor_pkg::ZSEL_ZERO;
                end else begin
                    dsp_cmd.zsel = taylor_pkg::ZSEL_POUT;
                end
                dsp_cmd.a = val[i];
                dsp_cmd.b = coef;
            end
            default: begin
            end
        endcase
    end

    // ----------------------------------------------------------
    // Write-back of truncated products
    // ----------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wb_q[0] <= '0;
            wb_q[1] <= '0;
        end else begin
            wb_q[0] <= issue_tag;
            wb_q[1] <= wb_q[0];
        end
    end

    assign m_frac = dsp_res.m[FB +: FW];

    always_ff @(posedge reset) begin
        if (state == INIT) begin
            val[0] <= taylor_pkg::FIXED_ONE;
        end else if (wb_q[1].valid && wb_q[1].to_val) begin
            val[wb_q[1].idx] <= m_frac;
        end
    end

    always_ff @(posedge reset) begin
        if (wb_q[1].valid && !wb_q[1].to_val) begin
            g[wb_q[1].idx] <= m_frac;
        end
    end

    // Result register, loaded once the accumulator has settled
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            calc_done <= 1'b0;
            result    <= '0;
        end else begin
            calc_done <= (state == DRAIN) && (rep == 2'd1);
            if (state == DRAIN && rep == 2'd1) begin
                result <= dsp_res.p[FB +: FW];
            end
        end
    end

    a_done_one_cycle: assert property (
        @(posedge reset) disable iff (clk)
        calc_done |=> !calc_done
    ) else $error("calc_done held longer than one cycle");

endmodule

//--- source/taylor_unit_top.sv
// Taylor unit top level: sequencer, coefficient ROM and MAC slice
`timescale 1ns/1ps

module taylor_unit_top #(
    parameter int N_TERMS = 10
) (
    input  logic                     reset,
    input  logic                     clk,
    input  logic                     do_calc,
    input  taylor_pkg::taylor_func_e func_sel,
    input  taylor_pkg::fixed_t       x_in,
    output logic                     calc_done,
    output taylor_pkg::fixed_t       result
);

    taylor_pkg::taylor_func_e func_sel_q;
    logic [3:0]               term_idx;
    taylor_pkg::fixed_t       coef;
    taylor_pkg::dsp_cmd_t     dsp_cmd;
    taylor_pkg::dsp_res_t     dsp_res;

    taylor_sequencer #(
        .N_TERMS (N_TERMS)
    ) taylor_sequencer_i (
        .reset      (reset),
        .clk        (clk),
        .do_calc    (do_calc),
        .func_sel   (func_sel),
        .x_in       (x_in),
        .calc_done  (calc_done),
        .result     (result),
        .func_sel_q (func_sel_q),
        .term_idx   (term_idx),
        .coef       (coef),
        .dsp_cmd    (dsp_cmd),
        .dsp_res    (dsp_res)
    );

    taylor_coef_rom taylor_coef_rom_i (
        .func_sel (func_sel_q),
        .term_idx (term_idx),
        .coef     (coef)
    );

    dsp_mac_slice dsp_mac_slice_i (
        .reset (reset),
        .clk   (clk),
        .cmd   (dsp_cmd),
        .res   (dsp_res)
    );

endmodule

//--- verif/taylor_unit_tb.sv
// Testbench clock, reset, stimulus, reference model, compare task and watchdog
`timescale 1ns/1ps

module taylor_unit_tb;

    localparam int N_TERMS   = 10;
    localparam int N_RANDOM  = 40;
    localparam int N_B2B     = 20;
    localparam int N_IGNORED = 5;
    localparam int N_TESTS   = 5 + 5 * N_RANDOM + N_B2B + N_IGNORED;

    // Length of one calculation in clock cycles
    localparam int CALC_CYCLES = 5 * N_TERMS + 5;

    // The clock port is named reset and the asynchronous reset port clk
    logic                     reset;
    logic                     clk;
    logic                     do_calc;
    taylor_pkg::taylor_func_e func_sel;
    taylor_pkg::fixed_t       x_in;
    logic                     calc_done;
    taylor_pkg::fixed_t       result;

    logic [31:0] rng_state;
    int          starts;
    int          pulses;

    taylor_unit_top #(
        .N_TERMS (N_TERMS)
    ) taylor_unit_top_i (
        .reset     (reset),
        .clk       (clk),
        .do_calc   (do_calc),
        .func_sel  (func_sel),
        .x_in      (x_in),
        .calc_done (calc_done),
        .result    (result)
    );

    initial begin
        reset = 1'b0;
        forever #5 reset = ~reset;
    end

    // Counts every rising edge of calc_done
    always @(posedge calc_done) begin
        pulses++;
    end

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    // Sign of the nth derivative at zero as -1, 0 or +1
    function automatic int deriv_at_zero(input taylor_pkg::taylor_func_e f, input int n);
        int sign;
        sign = ((n / 2) % 2 == 0) ? 1 : -1;
        case (f)
            taylor_pkg::FUNC_COS:  return (n % 2 == 0) ? sign : 0;
            taylor_pkg::FUNC_SIN:  return (n % 2 == 1) ? sign : 0;
            taylor_pkg::FUNC_EXP:  return 1;
            taylor_pkg::FUNC_COSH: return (n % 2 == 0) ? 1 : 0;
            taylor_pkg::FUNC_SINH: return (n % 2 == 1) ? 1 : 0;
            default:               return 0;
        endcase
    endfunction

    function automatic taylor_pkg::fixed_t taylor_ref(input taylor_pkg::taylor_func_e f,
                                                      input taylor_pkg::fixed_t x);
        taylor_pkg::fixed_t g   [1:N_TERMS];
        taylor_pkg::fixed_t val [0:N_TERMS];
        taylor_pkg::fixed_t recip;
        taylor_pkg::fixed_t c;
        logic signed [35:0] prod;
        logic signed [47:0] p;
        int                 j;
        for (j = 1; j <= N_TERMS; j++) begin
            // Q16 reciprocal of j rounded to nearest
            recip = 18'((65536 + j / 2) / j);
            prod  = x * recip;
            g[j]  = 18'(prod >>> 16);
        end
        val[0] = 18'sh10000;
        for (j = 1; j <= N_TERMS; j++) begin
            prod   = val[j-1] * g[j];
            val[j] = 18'(prod >>> 16);
        end
        p = '0;
        for (j = 0; j <= N_TERMS; j++) begin
            c    = 18'(deriv_at_zero(f, j) * 65536);
            prod = val[j] * c;
            p    = p + prod;
        end
        return p[33:16];
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Map a random word onto [-1.5, 1.5]
    function automatic taylor_pkg::fixed_t arg_from_rand(input logic [31:0] r);
        int span;
        span = int'(r[31:8] % 24'd196609);
        return 18'(span - 98304);
    endfunction

    // ----------------------------------------------------------
    // Checks and stimulus tasks
    // ----------------------------------------------------------
    task automatic check_equal(input logic signed [47:0] actual,
                               input logic signed [47:0] expected, input string what);
        if (actual !== expected) begin
            $display("ERROR %0t: %s expected %0d actual %0d", $time, what, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic pulse_do_calc(input taylor_pkg::taylor_func_e f, input taylor_pkg::fixed_t x);
        @(negedge reset);
        do_calc  = 1'b1;
        func_sel = f;
        x_in     = x;
        @(negedge reset);
        do_calc = 1'b0;
    endtask

    task automatic wait_done(output taylor_pkg::fixed_t got);
        while (calc_done !== 1'b1) begin
            @(negedge reset);
        end
        got = result;
        @(negedge reset);
        check_equal(calc_done, 1'b0, "calc_done one cycle wide");
    endtask

    task automatic run_calc(input taylor_pkg::taylor_func_e f, input taylor_pkg::fixed_t x,
                            output taylor_pkg::fixed_t got);
        pulse_do_calc(f, x);
        starts++;
        wait_done(got);
        check_equal(pulses, starts, "calc_done pulses per request");
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        taylor_pkg::taylor_func_e funcs [5];
        taylor_pkg::fixed_t       zero_expect [5];
        taylor_pkg::fixed_t       x;
        taylor_pkg::fixed_t       x2;
        taylor_pkg::fixed_t       got;
        int                       k;
        int                       n;
        clk         = 1'b1;
        do_calc     = 1'b0;
        func_sel    = taylor_pkg::FUNC_COS;
        x_in        = '0;
        rng_state   = 32'hef9e;
        starts      = 0;
        funcs = '{taylor_pkg::FUNC_COS, taylor_pkg::FUNC_SIN, taylor_pkg::FUNC_EXP,
                  taylor_pkg::FUNC_COSH, taylor_pkg::FUNC_SINH};
        zero_expect = '{18'sh10000, 18'sh0, 18'sh10000, 18'sh10000, 18'sh0};
        repeat (16) @(posedge reset);
        @(negedge reset);
        clk = 1'b0;

        // Idle outputs after reset
        repeat (5) begin
            @(negedge reset);
            check_equal(calc_done, 1'b0, "calc_done idle after reset");
            check_equal(result, '0, "result after reset");
        end

        // All functions at x = 0
        for (k = 0; k < 5; k++) begin
            run_calc(funcs[k], '0, got);
            check_equal(got, zero_expect[k], $sformatf("func %0d at x = 0", k));
        end

        // Random arguments for every function
        for (k = 0; k < 5; k++) begin
            for (n = 0; n < N_RANDOM; n++) begin
                rng_state = lcg_next(rng_state);
                x = arg_from_rand(rng_state);
                run_calc(funcs[k], x, got);
                check_equal(got, taylor_ref(funcs[k], x), $sformatf("func %0d x %0d", k, x));
            end
        end

        // Back-to-back requests with a new function each time
        for (n = 0; n < N_B2B; n++) begin
            rng_state = lcg_next(rng_state);
            x = arg_from_rand(rng_state);
            run_calc(funcs[(n * 2) % 5], x, got);
            check_equal(got, taylor_ref(funcs[(n * 2) % 5], x),
                        $sformatf("back-to-back run %0d x %0d", n, x));
        end

        // A second do_calc while busy must be ignored
        for (n = 0; n < N_IGNORED; n++) begin
            rng_state = lcg_next(rng_state);
            x = arg_from_rand(rng_state);
            rng_state = lcg_next(rng_state);
            x2 = arg_from_rand(rng_state);
            pulse_do_calc(funcs[n], x);
            starts++;
            repeat (n * 7) @(negedge reset);
            pulse_do_calc(funcs[(n + 2) % 5], x2);
            wait_done(got);
            check_equal(got, taylor_ref(funcs[n], x), $sformatf("ignored do_calc run %0d", n));
            repeat (2 * CALC_CYCLES) @(negedge reset);
            check_equal(pulses, starts, "no extra calc_done pulse");
        end

        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        repeat ((N_TESTS + 4) * 200) @(posedge reset);
        $display("Timeout: the tests did not finish within %0d clock cycles",
                 (N_TESTS + 4) * 200);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- vlog.f
source/taylor_pkg.sv
source/taylor_coef_rom.sv
source/dsp_mac_slice.sv
source/taylor_sequencer.sv
source/taylor_unit_top.sv
verif/taylor_unit_tb.sv

//--- Bender.yml
package:
  name: taylor_unit

sources:
  - source/taylor_pkg.sv
  - source/taylor_coef_rom.sv
  - source/dsp_mac_slice.sv
  - source/taylor_sequencer.sv
  - source/taylor_unit_top.sv
  - target: test
    files:
      - verif/taylor_unit_tb.sv
